// File: dm_csr.f
+incdir+.
dm_pkg.sv
dm_dmi_resp.sv
dm_run_ctrl.sv
dm_abstract_regs.sv
dm_csr_top.sv
dm_csr_sva.sv
tb_dm_csr.sv

// File: Bender.yml
package:
  name: dm_csr

sources:
  - include_dirs:
      - .
    files:
      - dm_pkg.sv
      - dm_dmi_resp.sv
      - dm_run_ctrl.sv
      - dm_abstract_regs.sv
      - dm_csr_top.sv
      - target: simulation
        files:
          - dm_csr_sva.sv
          - tb_dm_csr.sv

// File: tb_dm_csr.sv
`timescale 1ns/1ps
`include "dm_consts.svh"

module tb_dm_csr;
  localparam int max_cycles = 2000;   // roughly ten times the full test run

  logic                               clk_i = 1'b0;
  logic                               rst_ni, dmi_rst_ni;
  logic                               dmi_req_valid_i, dmi_req_ready_o;
  dm_pkg::dmi_req_t                   dmi_req_i;
  logic                               dmi_resp_valid_o, dmi_resp_ready_i;
  dm_pkg::dmi_resp_t                  dmi_resp_o;
  logic                               ndmreset_o, dmactive_o, clear_resumeack_o;
  logic [`DM_NR_HARTS-1:0]            halted_i, unavailable_i, resumeack_i;
  logic [`DM_NR_HARTS-1:0]            haltreq_o, resumereq_o;
  logic [19:0]                        hartsel_o;
  logic                               cmd_valid_o, cmderror_valid_i, cmdbusy_i, data_valid_i;
  logic [31:0]                        cmd_o;
  dm_pkg::cmderr_e                    cmderror_i;
  logic [`DM_PROGBUF_SIZE-1:0][31:0]  progbuf_o;
  logic [`DM_DATA_COUNT-1:0][31:0]    data_o, data_i;

  int          cycles = 0;
  int          cmd_pulses = 0;
  int          ack_pulses = 0;
  integer      seed = 32'h0982d713;
  logic [31:0] data_exp [`DM_DATA_COUNT];   // what the data words should hold

  dm_csr_top dm_csr_top_i (.*);

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles == max_cycles) begin
      $display("timeout, the tests did not finish within %0d cycles", max_cycles);
      $display("Test failed");
      $fatal(1);
    end
  end

  // count single-cycle pulses in the stable low phase
  always @(negedge clk_i) begin
    if (cmd_valid_o === 1'b1) cmd_pulses++;
    if (clear_resumeack_o === 1'b1) ack_pulses++;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // dmstatus fields per debug spec 0.13, single hart selected
  function automatic logic [31:0] expected_dmstatus(input logic halted, input logic unavail,
                                                    input logic havereset, input logic resumeack);
    logic [31:0] s;
    s        = 32'(`DM_VERSION);
    s[7]     = 1'b1;   // authenticated
    s[9:8]   = {2{halted & ~unavail}};
    s[11:10] = {2{~halted & ~unavail}};
    s[13:12] = {2{unavail}};
    s[17:16] = {2{resumeack}};
    s[19:18] = {2{havereset}};
    return s;
  endfunction

  function automatic logic [31:0] expected_abstractcs(input logic busy, input logic [2:0] cmderr);
    logic [31:0] v;
    v        = '0;
    v[28:24] = 5'(`DM_PROGBUF_SIZE);
    v[12]    = busy;
    v[10:8]  = cmderr;
    v[3:0]   = 4'(`DM_DATA_COUNT);
    return v;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  // one request, returns the response seen right after the accept edge
  task automatic dmi_access(input dm_pkg::dmi_op_e req_op, input logic [6:0] req_addr,
                            input logic [31:0] req_data, output dm_pkg::dmi_resp_t resp);
    @(posedge clk_i);
    dmi_req_valid_i <= 1'b1;
    dmi_req_i       <= '{addr: req_addr, data: req_data, op: req_op};
    @(negedge clk_i);
    while (!dmi_req_ready_o) @(negedge clk_i);
    @(posedge clk_i);   // accepted here
    dmi_req_valid_i <= 1'b0;
    @(negedge clk_i);
    compare("response valid", dmi_resp_valid_o, 1'b1);
    resp = dmi_resp_o;
  endtask

  task automatic dmi_write(input logic [6:0] addr, input logic [31:0] data);
    dm_pkg::dmi_resp_t resp;
    dmi_access(dm_pkg::DMI_WRITE, addr, data, resp);
    compare("write response", resp, {32'h0, dm_pkg::DMI_SUCCESS});
  endtask

  task automatic dmi_read(input logic [6:0] addr, output logic [31:0] data);
    dm_pkg::dmi_resp_t resp;
    dmi_access(dm_pkg::DMI_READ, addr, 32'h0, resp);
    compare("read response code", resp.resp, dm_pkg::DMI_SUCCESS);
    data = resp.data;
  endtask

  task automatic read_check(input logic [6:0] addr, input logic [31:0] exp, input string what);
    logic [31:0] got;
    dmi_read(addr, got);
    compare(what, got, exp);
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic reset_state();
    compare("control outputs after reset", {dmi_resp_valid_o, cmd_valid_o, haltreq_o,
            resumereq_o, ndmreset_o, dmactive_o, clear_resumeack_o}, '0);
    read_check(dm_pkg::DMSTATUS, expected_dmstatus(1'b0, 1'b0, 1'b1, 1'b0), "dmstatus reset");
  endtask

  task automatic run_control();
    int acks;
    dmi_write(dm_pkg::DMCONTROL, 32'hA400_000D);   // haltreq, dmactive, unsupported bits
    compare("haltreq_o", haltreq_o, 1'b1);
    compare("dmactive_o", dmactive_o, 1'b1);
    read_check(dm_pkg::DMCONTROL, 32'h8000_0001, "dmcontrol read-back");
    @(posedge clk_i);
    halted_i <= 1'b1;
    dmi_write(dm_pkg::DMCONTROL, 32'h1000_0001);   // ackhavereset
    read_check(dm_pkg::DMSTATUS, expected_dmstatus(1'b1, 1'b0, 1'b0, 1'b0), "dmstatus halted");
    acks = ack_pulses;
    dmi_write(dm_pkg::DMCONTROL, 32'h4000_0001);
    compare("clear_resumeack pulses", ack_pulses - acks, 1);
    compare("resumereq_o", resumereq_o, 1'b1);
    @(posedge clk_i);
    resumeack_i <= 1'b1;
    halted_i    <= 1'b0;
    idle_cycles(2);
    @(negedge clk_i);
    compare("resumereq_o after resumeack", resumereq_o, 1'b0);
    read_check(dm_pkg::DMCONTROL, 32'h0000_0001, "dmcontrol after resumeack");
    read_check(dm_pkg::DMSTATUS, expected_dmstatus(1'b0, 1'b0, 1'b0, 1'b1), "dmstatus resumed");
    @(posedge clk_i);
    resumeack_i <= 1'b0;
    dmi_write(dm_pkg::DMCONTROL, 32'h0000_0003);   // pulse ndmreset
    compare("ndmreset_o", ndmreset_o, 1'b1);
    dmi_write(dm_pkg::DMCONTROL, 32'h0000_0001);
    read_check(dm_pkg::DMSTATUS, expected_dmstatus(1'b0, 1'b0, 1'b1, 1'b0), "havereset again");
    // hartsello 1 and hartselhi 1 select hart 0x401, which does not exist
    dmi_write(dm_pkg::DMCONTROL, 32'h0001_0041);
    compare("hartsel_o", hartsel_o, 20'h00401);
    read_check(dm_pkg::DMSTATUS, 32'(`DM_VERSION) | 32'h0000_C080, "dmstatus nonexistent hart");
    dmi_write(dm_pkg::DMCONTROL, 32'h8000_0000);   // haltreq without dmactive
    compare("outputs while inactive",
            {haltreq_o, resumereq_o, dmactive_o, ndmreset_o, hartsel_o}, '0);
    read_check(dm_pkg::DMCONTROL, 32'h0, "dmcontrol inactive");
    dmi_write(dm_pkg::DMCONTROL, 32'h0000_0001);
  endtask

  task automatic register_rw();
    logic [31:0] word;
    int          cmds;
    for (int i = 0; i < `DM_DATA_COUNT; i++) begin
      data_exp[i] = $random(seed);
      dmi_write(dm_pkg::DATA0 + 7'(i), data_exp[i]);
      compare("data_o", data_o[i], data_exp[i]);
    end
    for (int i = 0; i < `DM_DATA_COUNT; i++) begin
      read_check(dm_pkg::DATA0 + 7'(i), data_exp[i], "data read-back");
    end
    for (int i = 0; i < `DM_PROGBUF_SIZE; i++) begin
      word = $random(seed);
      dmi_write(dm_pkg::PROGBUF0 + 7'(i), word);
      compare("progbuf_o", progbuf_o[i], word);
      read_check(dm_pkg::PROGBUF0 + 7'(i), word, "progbuf read-back");
    end
    cmds = cmd_pulses;
    word = $random(seed);
    dmi_write(dm_pkg::COMMAND, word);
    idle_cycles(3);
    compare("cmd_valid pulses", cmd_pulses - cmds, 1);
    compare("cmd_o", cmd_o, word);
    @(posedge clk_i);
    for (int i = 0; i < `DM_DATA_COUNT; i++) begin
      data_exp[i] = $random(seed);
      data_i[i]  <= data_exp[i];
    end
    data_valid_i <= 1'b1;
    @(posedge clk_i);
    data_valid_i <= 1'b0;
    for (int i = 0; i < `DM_DATA_COUNT; i++) begin
      read_check(dm_pkg::DATA0 + 7'(i), data_exp[i], "data after data_valid_i");
    end
  endtask

  task automatic busy_error();
    dm_pkg::dmi_resp_t resp;
    @(posedge clk_i);
    cmdbusy_i <= 1'b1;
    dmi_access(dm_pkg::DMI_WRITE, dm_pkg::DATA0, ~data_exp[0], resp);
    compare("busy write response", resp, {32'h0, dm_pkg::DMI_BUSY});
    compare("data_o while busy", data_o[0], data_exp[0]);
    read_check(dm_pkg::ABSTRACTCS, expected_abstractcs(1'b1, dm_pkg::CMDERR_BUSY), "cmderr busy");
    @(posedge clk_i);
    cmdbusy_i <= 1'b0;
    dmi_write(dm_pkg::ABSTRACTCS, 32'h0000_0700);   // write 1s to cmderr
    read_check(dm_pkg::ABSTRACTCS, expected_abstractcs(1'b0, dm_pkg::CMDERR_NONE), "cmderr clear");
    @(posedge clk_i);
    cmderror_valid_i <= 1'b1;
    cmderror_i       <= dm_pkg::CMDERR_EXCEPTION;
    @(posedge clk_i);
    cmderror_valid_i <= 1'b0;
    read_check(dm_pkg::ABSTRACTCS, expected_abstractcs(1'b0, dm_pkg::CMDERR_EXCEPTION),
               "cmderr from hart");
    dmi_write(dm_pkg::ABSTRACTCS, 32'h0000_0700);
  endtask

  task automatic back_pressure();
    @(posedge clk_i);
    dmi_resp_ready_i <= 1'b0;
    dmi_req_valid_i  <= 1'b1;
    dmi_req_i        <= '{addr: dm_pkg::DATA0, data: 32'h0, op: dm_pkg::DMI_READ};
    @(posedge clk_i);
    dmi_req_i <= '{addr: dm_pkg::DATA0 + 7'd1, data: 32'h0, op: dm_pkg::DMI_READ};
    @(posedge clk_i);
    dmi_req_i <= '{addr: 7'h13, data: 32'h0, op: dm_pkg::DMI_READ};   // no register here
    idle_cycles(2);
    @(negedge clk_i);
    compare("ready with full queue", dmi_req_ready_o, 1'b0);
    compare("first response", dmi_resp_o, {data_exp[0], dm_pkg::DMI_SUCCESS});
    @(posedge clk_i);
    dmi_resp_ready_i <= 1'b1;
    @(negedge clk_i);
    compare("first response held", dmi_resp_o, {data_exp[0], dm_pkg::DMI_SUCCESS});
    @(negedge clk_i);
    compare("second response", dmi_resp_o, {data_exp[1], dm_pkg::DMI_SUCCESS});
    @(posedge clk_i);   // third request accepted here
    dmi_req_valid_i <= 1'b0;
    @(negedge clk_i);
    compare("unknown address response", dmi_resp_o, {32'h0, dm_pkg::DMI_SUCCESS});
    compare("unknown address valid", dmi_resp_valid_o, 1'b1);
    idle_cycles(2);
  endtask

  initial begin
    rst_ni           = 1'b0;
    dmi_rst_ni       = 1'b1;
    dmi_req_valid_i  = 1'b0;
    dmi_req_i        = '0;
    dmi_resp_ready_i = 1'b1;
    halted_i         = '0;
    unavailable_i    = '0;
    resumeack_i      = '0;
    cmderror_valid_i = 1'b0;
    cmderror_i       = dm_pkg::CMDERR_NONE;
    cmdbusy_i        = 1'b0;
    data_valid_i     = 1'b0;
    data_i           = '0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    reset_state();
    run_control();
    register_rw();
    busy_error();
    back_pressure();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: dm_csr_sva.sv
`timescale 1ns/1ps
`include "dm_consts.svh"

module dm_csr_sva (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     dmi_rst_ni,
  input logic                     dmi_resp_valid_o,
  input logic                     dmi_resp_ready_i,
  input dm_pkg::dmi_resp_t        dmi_resp_o,
  input logic                     dmactive_o,
  input logic [`DM_NR_HARTS-1:0]  haltreq_o,
  input logic [`DM_NR_HARTS-1:0]  resumereq_o,
  input logic                     cmd_valid_o
);

  // queued response holds until the dtm pops it
  resp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni || !dmi_rst_ni)
    dmi_resp_valid_o && !dmi_resp_ready_i |=> dmi_resp_valid_o && $stable(dmi_resp_o))
    else $error("dmi response changed while waiting for ready");

  no_req_inactive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !dmactive_o |-> haltreq_o == '0 && resumereq_o == '0)
    else $error("halt or resume request while the module is inactive");

  cmd_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_o |=> !cmd_valid_o)
    else $error("cmd_valid_o high for two cycles in a row");

endmodule

bind dm_csr_top dm_csr_sva dm_csr_sva_i (.*);

// File: dm_csr_top.sv
`timescale 1ns/1ps
`include "dm_consts.svh"

module dm_csr_top (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 dmi_rst_ni,
  // dmi
  input  logic                                 dmi_req_valid_i,
  output logic                                 dmi_req_ready_o,
  input  dm_pkg::dmi_req_t                     dmi_req_i,
  output logic                                 dmi_resp_valid_o,
  input  logic                                 dmi_resp_ready_i,
  output dm_pkg::dmi_resp_t                    dmi_resp_o,
  // run control
  output logic                                 ndmreset_o,
  output logic                                 dmactive_o,
  input  logic [`DM_NR_HARTS-1:0]              halted_i,
  input  logic [`DM_NR_HARTS-1:0]              unavailable_i,
  input  logic [`DM_NR_HARTS-1:0]              resumeack_i,
  output logic [19:0]                          hartsel_o,
  output logic [`DM_NR_HARTS-1:0]              haltreq_o,
  output logic [`DM_NR_HARTS-1:0]              resumereq_o,
  output logic                                 clear_resumeack_o,
  // abstract commands
  output logic                                 cmd_valid_o,
  output logic [31:0]                          cmd_o,
  input  logic                                 cmderror_valid_i,
  input  dm_pkg::cmderr_e                      cmderror_i,
  input  logic                                 cmdbusy_i,
  output logic [`DM_PROGBUF_SIZE-1:0][31:0]    progbuf_o,
  output logic [`DM_DATA_COUNT-1:0][31:0]      data_o,
  input  logic [`DM_DATA_COUNT-1:0][31:0]      data_i,
  input  logic                                 data_valid_i
);
  logic             req_fire;
  dm_pkg::reg_rsp_t run_rsp, abs_rsp;

  dm_dmi_resp dm_dmi_resp_i (
    .clk_i, .rst_ni, .dmi_rst_ni, .dmi_req_valid_i, .dmi_resp_ready_i,
    .run_rsp_i   (run_rsp),
    .abs_rsp_i   (abs_rsp),
    .dmi_req_ready_o,
    .req_fire_o  (req_fire),
    .dmi_resp_valid_o, .dmi_resp_o
  );

  dm_run_ctrl dm_run_ctrl_i (
    .clk_i, .rst_ni,
    .req_fire_i  (req_fire),
    .req_i       (dmi_req_i),
    .halted_i, .unavailable_i, .resumeack_i,
    .rsp_o       (run_rsp),
    .dmactive_o, .ndmreset_o, .hartsel_o, .haltreq_o, .resumereq_o, .clear_resumeack_o
  );

  dm_abstract_regs dm_abstract_regs_i (
    .clk_i, .rst_ni,
    .req_fire_i  (req_fire),
    .req_i       (dmi_req_i),
    .dmactive_i  (dmactive_o),
    .cmdbusy_i, .cmderror_valid_i, .cmderror_i, .data_valid_i, .data_i,
    .rsp_o       (abs_rsp),
    .cmd_valid_o, .cmd_o, .data_o, .progbuf_o
  );

endmodule

// File: dm_abstract_regs.sv
`timescale 1ns/1ps
`include "dm_consts.svh"

module dm_abstract_regs (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 req_fire_i,
  input  dm_pkg::dmi_req_t                     req_i,
  input  logic                                 dmactive_i,
  input  logic                                 cmdbusy_i,
  input  logic                                 cmderror_valid_i,
  input  dm_pkg::cmderr_e                      cmderror_i,
  input  logic                                 data_valid_i,
  input  logic [`DM_DATA_COUNT-1:0][31:0]      data_i,
  output dm_pkg::reg_rsp_t                     rsp_o,
  output logic                                 cmd_valid_o,
  output logic [31:0]                          cmd_o,
  output logic [`DM_DATA_COUNT-1:0][31:0]      data_o,
  output logic [`DM_PROGBUF_SIZE-1:0][31:0]    progbuf_o
);
  localparam int data_idx_w = (`DM_DATA_COUNT > 1) ? $clog2(`DM_DATA_COUNT) : 1;
  localparam int pb_idx_w   = (`DM_PROGBUF_SIZE > 1) ? $clog2(`DM_PROGBUF_SIZE) : 1;

  logic [`DM_DATA_COUNT-1:0][31:0]    data_d, data_q;
  logic [`DM_PROGBUF_SIZE-1:0][31:0]  progbuf_d, progbuf_q;
  logic [31:0]                        command_d, command_q;
  logic                               cmd_valid_d, cmd_valid_q;
  dm_pkg::cmderr_e                    cmderr_d, cmderr_q;
  dm_pkg::dm_wdata_u                  wdata;
  dm_pkg::abstractcs_t                abstractcs;
  logic [6:0]                         data_off, pb_off;
  logic                               is_data, is_pb, is_acs, is_cmd;
  logic                               rd, wr;

  // ----------------------------------------
  // address decode
  // ----------------------------------------
  assign data_off  = req_i.addr - dm_pkg::DATA0;
  assign pb_off    = req_i.addr - dm_pkg::PROGBUF0;
  assign is_data   = req_i.addr >= dm_pkg::DATA0 && data_off < `DM_DATA_COUNT;
  assign is_pb     = req_i.addr >= dm_pkg::PROGBUF0 && pb_off < `DM_PROGBUF_SIZE;
  assign is_acs    = req_i.addr == dm_pkg::ABSTRACTCS;
  assign is_cmd    = req_i.addr == dm_pkg::COMMAND;
  assign rd        = req_fire_i && req_i.op == dm_pkg::DMI_READ;
  assign wr        = req_fire_i && req_i.op == dm_pkg::DMI_WRITE;
  assign wdata.raw = req_i.data;

  always_comb begin
    abstractcs             = '0;
    abstractcs.datacount   = 4'(`DM_DATA_COUNT);
    abstractcs.progbufsize = 5'(`DM_PROGBUF_SIZE);
    abstractcs.busy        = cmdbusy_i;
    abstractcs.cmderr      = cmderr_q;
  end

  always_comb begin
    data_d      = data_q;
    progbuf_d   = progbuf_q;
    command_d   = command_q;
    cmderr_d    = cmderr_q;
    cmd_valid_d = 1'b0;
    rsp_o       = '0;
    rsp_o.hit   = req_fire_i && (is_data || is_pb || is_acs || is_cmd);
    // abstractcs reads stay open so busy can be polled
    if (rsp_o.hit && cmdbusy_i && (wr || !is_acs)) begin
      rsp_o.busy = 1'b1;
      if (cmderr_q == dm_pkg::CMDERR_NONE) cmderr_d = dm_pkg::CMDERR_BUSY;
    end else if (wr) begin
      if (is_data) data_d[data_off[data_idx_w-1:0]] = wdata.raw;
      if (is_pb) progbuf_d[pb_off[pb_idx_w-1:0]] = wdata.raw;
      if (is_cmd) begin
        command_d   = wdata.raw;
        cmd_valid_d = 1'b1;   // start the command
      end
      if (is_acs) cmderr_d = dm_pkg::cmderr_e'(cmderr_q & ~wdata.abstractcs.cmderr); // w1c
    end else if (rd) begin
      if (is_data) rsp_o.rdata = data_q[data_off[data_idx_w-1:0]];
      if (is_pb) rsp_o.rdata = progbuf_q[pb_off[pb_idx_w-1:0]];
      if (is_acs) rsp_o.rdata = abstractcs;
    end
    if (cmderror_valid_i) cmderr_d = cmderror_i;   // hart error wins
    if (data_valid_i) data_d = data_i;
    if (!dmactive_i) begin
      data_d      = '0;
      progbuf_d   = '0;
      command_d   = '0;
      cmd_valid_d = 1'b0;
      cmderr_d    = dm_pkg::CMDERR_NONE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmderr_q    <= dm_pkg::CMDERR_NONE;
      cmd_valid_q <= 1'b0;
    end else begin
      cmderr_q    <= cmderr_d;
      cmd_valid_q <= cmd_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    data_q    <= data_d;
    progbuf_q <= progbuf_d;
    command_q <= command_d;
  end

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = command_q;
  assign data_o      = data_q;
  assign progbuf_o   = progbuf_q;

endmodule

// File: dm_run_ctrl.sv
`timescale 1ns/1ps
`include "dm_consts.svh"

module dm_run_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_fire_i,
  input  dm_pkg::dmi_req_t          req_i,
  input  logic [`DM_NR_HARTS-1:0]   halted_i,
  input  logic [`DM_NR_HARTS-1:0]   unavailable_i,
  input  logic [`DM_NR_HARTS-1:0]   resumeack_i,
  output dm_pkg::reg_rsp_t          rsp_o,
  output logic                      dmactive_o,
  output logic                      ndmreset_o,
  output logic [19:0]               hartsel_o,
  output logic [`DM_NR_HARTS-1:0]   haltreq_o,
  output logic [`DM_NR_HARTS-1:0]   resumereq_o,
  output logic                      clear_resumeack_o
);
  localparam int hart_sel_w = (`DM_NR_HARTS == 1) ? 1 : $clog2(`DM_NR_HARTS);

  dm_pkg::dmcontrol_t        dmcontrol_d, dmcontrol_q;
  dm_pkg::dm_wdata_u         wdata;
  logic [`DM_NR_HARTS-1:0]   havereset_d, havereset_q;
  logic [hart_sel_w-1:0]     sel;
  logic                      sel_valid;
  logic                      halted_sel, unavail_sel, resumeack_sel, havereset_sel;
  logic                      wr_ctrl;
  logic [31:0]               dmstatus;

  assign hartsel_o  = {dmcontrol_q.hartselhi, dmcontrol_q.hartsello};
  assign dmactive_o = dmcontrol_q.dmactive;
  assign ndmreset_o = dmcontrol_q.ndmreset;

  // status of the selected hart, masked when it does not exist
  assign sel           = hartsel_o[hart_sel_w-1:0];
  assign sel_valid     = hartsel_o < `DM_NR_HARTS;
  assign halted_sel    = sel_valid & halted_i[sel];
  assign unavail_sel   = sel_valid & unavailable_i[sel];
  assign resumeack_sel = sel_valid & resumeack_i[sel];
  assign havereset_sel = sel_valid & havereset_q[sel];

  assign wdata.raw = req_i.data;
  assign wr_ctrl   = req_fire_i && req_i.op == dm_pkg::DMI_WRITE
                     && req_i.addr == dm_pkg::DMCONTROL;

  always_comb begin
    dmcontrol_d       = dmcontrol_q;
    havereset_d       = havereset_q;
    clear_resumeack_o = 1'b0;
    if (wr_ctrl) begin
      dmcontrol_d = wdata.dmcontrol;
      if (wdata.dmcontrol.ackhavereset && sel_valid) havereset_d[sel] = 1'b0;
    end
    // unsupported fields read as zero
    dmcontrol_d.hartreset       = 1'b0;
    dmcontrol_d.ackhavereset    = 1'b0;
    dmcontrol_d.zero1           = 1'b0;
    dmcontrol_d.hasel           = 1'b0;
    dmcontrol_d.zero0           = 2'b00;
    dmcontrol_d.setresethaltreq = 1'b0;
    dmcontrol_d.clrresethaltreq = 1'b0;
    if (!dmcontrol_q.resumereq && dmcontrol_d.resumereq) clear_resumeack_o = 1'b1;
    if (dmcontrol_q.resumereq && resumeack_sel) dmcontrol_d.resumereq = 1'b0;
    if (ndmreset_o) havereset_d = '1;   // all harts see the reset
    // inactive module keeps only dmactive
    if (!dmcontrol_d.dmactive) dmcontrol_d = '{dmactive: 1'b0, default: '0};
  end

  always_comb begin
    dmstatus        = '0;
    dmstatus[3:0]   = 4'(`DM_VERSION);
    dmstatus[7]     = 1'b1;                            // authenticated
    dmstatus[9:8]   = {2{halted_sel & ~unavail_sel}};
    dmstatus[11:10] = {2{sel_valid & ~halted_sel & ~unavail_sel}};
    dmstatus[13:12] = {2{unavail_sel}};
    dmstatus[15:14] = {2{~sel_valid}};                 // nonexistent
    dmstatus[17:16] = {2{resumeack_sel}};
    dmstatus[19:18] = {2{havereset_sel}};
  end

  always_comb begin
    rsp_o     = '0;
    rsp_o.hit = req_fire_i && (req_i.addr == dm_pkg::DMCONTROL
                               || req_i.addr == dm_pkg::DMSTATUS);
    if (rsp_o.hit && req_i.op == dm_pkg::DMI_READ) begin
      rsp_o.rdata = (req_i.addr == dm_pkg::DMSTATUS) ? dmstatus : dmcontrol_q;
    end
  end

  always_comb begin
    haltreq_o   = '0;
    resumereq_o = '0;
    if (sel_valid) begin
      haltreq_o[sel]   = dmcontrol_q.haltreq;
      resumereq_o[sel] = dmcontrol_q.resumereq;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmcontrol_q <= '0;
      havereset_q <= '1;   // harts come out of power-on reset
    end else begin
      dmcontrol_q <= dmcontrol_d;
      havereset_q <= havereset_d;
    end
  end

endmodule

// File: dm_dmi_resp.sv
`timescale 1ns/1ps
`include "dm_consts.svh"

module dm_dmi_resp (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               dmi_rst_ni,
  input  logic               dmi_req_valid_i,
  input  logic               dmi_resp_ready_i,
  input  dm_pkg::reg_rsp_t   run_rsp_i,
  input  dm_pkg::reg_rsp_t   abs_rsp_i,
  output logic               dmi_req_ready_o,
  output logic               req_fire_o,
  output logic               dmi_resp_valid_o,
  output dm_pkg::dmi_resp_t  dmi_resp_o
);
  localparam int depth = `DM_RESP_DEPTH;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

  dm_pkg::dmi_resp_t [depth-1:0] mem_q;
  dm_pkg::dmi_resp_t             resp_in;
  logic [ptr_w-1:0]              wptr_q, rptr_q;
  logic [ptr_w:0]                count_q;
  logic                          pop;

  assign dmi_req_ready_o  = count_q != depth;   // low only when full
  assign req_fire_o       = dmi_req_valid_i & dmi_req_ready_o;
  assign dmi_resp_valid_o = count_q != 0;
  assign pop              = dmi_resp_valid_o & dmi_resp_ready_i;
  assign dmi_resp_o       = mem_q[rptr_q];

  // busy from either block overrides the read data
  always_comb begin
    resp_in = '0;
    if (run_rsp_i.busy || abs_rsp_i.busy) begin
      resp_in.resp = dm_pkg::DMI_BUSY;
    end else begin
      resp_in.resp = dm_pkg::DMI_SUCCESS;
      resp_in.data = (run_rsp_i.hit ? run_rsp_i.rdata : 32'h0)
                   | (abs_rsp_i.hit ? abs_rsp_i.rdata : 32'h0);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else if (!dmi_rst_ni) begin   // dtm side flush
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (req_fire_o) wptr_q <= (wptr_q == ptr_w'(depth - 1)) ? '0 : wptr_q + 1'b1;
      if (pop) rptr_q <= (rptr_q == ptr_w'(depth - 1)) ? '0 : rptr_q + 1'b1;
      count_q <= count_q + (ptr_w+1)'(req_fire_o) - (ptr_w+1)'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire_o) mem_q[wptr_q] <= resp_in;
  end

endmodule

// File: dm_pkg.sv
package dm_pkg;

  // request op and response code share the 2-bit field
  typedef enum logic [1:0] {
    DMI_NOP   = 2'h0,
    DMI_READ  = 2'h1,
    DMI_WRITE = 2'h2,
    DMI_BUSY  = 2'h3
  } dmi_op_e;

  localparam dmi_op_e DMI_SUCCESS = DMI_NOP;
  localparam dmi_op_e DMI_ERROR   = DMI_WRITE;

  typedef struct packed {
    logic [6:0]  addr;
    logic [31:0] data;
    dmi_op_e     op;
  } dmi_req_t;

  typedef struct packed {
    logic [31:0] data;
    dmi_op_e     resp;
  } dmi_resp_t;

  // per-block answer to the current request
  typedef struct packed {
    logic        hit;
    logic        busy;
    logic [31:0] rdata;
  } reg_rsp_t;

  typedef struct packed {
    logic       haltreq;
    logic       resumereq;
    logic       hartreset;
    logic       ackhavereset;
    logic       zero1;
    logic       hasel;
    logic [9:0] hartsello;
    logic [9:0] hartselhi;
    logic [1:0] zero0;
    logic       setresethaltreq;
    logic       clrresethaltreq;
    logic       ndmreset;
    logic       dmactive;
  } dmcontrol_t;

  typedef struct packed {
    logic [2:0]  zero3;
    logic [4:0]  progbufsize;
    logic [10:0] zero2;
    logic        busy;
    logic        zero1;
    logic [2:0]  cmderr;
    logic [3:0]  zero0;
    logic [3:0]  datacount;
  } abstractcs_t;

  // one dmi write word, seen by each block through its own register view
  typedef union packed {
    logic [31:0] raw;
    dmcontrol_t  dmcontrol;
    abstractcs_t abstractcs;
  } dm_wdata_u;

  typedef enum logic [2:0] {
    CMDERR_NONE          = 3'd0,
    CMDERR_BUSY          = 3'd1,
    CMDERR_NOT_SUPPORTED = 3'd2,
    CMDERR_EXCEPTION     = 3'd3,
    CMDERR_HALT_RESUME   = 3'd4,
    CMDERR_BUS           = 3'd5,
    CMDERR_OTHER         = 3'd7
  } cmderr_e;

  // ----------------------------------------
  // register addresses
  // ----------------------------------------
  localparam logic [6:0] DATA0      = 7'h04;
  localparam logic [6:0] DMCONTROL  = 7'h10;
  localparam logic [6:0] DMSTATUS   = 7'h11;
  localparam logic [6:0] ABSTRACTCS = 7'h16;
  localparam logic [6:0] COMMAND    = 7'h17;
  localparam logic [6:0] PROGBUF0   = 7'h20;

endpackage

// File: dm_consts.svh
`ifndef DM_CONSTS_SVH
`define DM_CONSTS_SVH

// debug module configuration
`define DM_NR_HARTS      1
`define DM_DATA_COUNT    2
`define DM_PROGBUF_SIZE  8

`define DM_RESP_DEPTH    2   // dmi response queue entries
`define DM_VERSION       2   // dmstatus.version, spec 0.13

`endif
